//--- icb1to4_bus.f
+incdir+.
icb_bus_pkg.sv
icb_region_decode.sv
icb_outs_fifo.sv
icb_splt_route.sv
icb1to4_bus.sv
tb_clk_gen.sv
tb_icb1to4_bus.sv

//--- icb1to4_bus.sv
`timescale 1ns/1ps
`include "icb_bus_consts.svh"

module icb1to4_bus (
  input  logic               clk,
  input  logic               i_arst_n,
  input  logic [2:0]         i_port_enable,  // Regions of ports 0 to 2

  input  logic               i_icb_cmd_valid,
  output logic               o_icb_cmd_ready,
  input  icb_bus_pkg::addr_t i_icb_cmd_addr,
  input  logic               i_icb_cmd_read,
  input  icb_bus_pkg::data_t i_icb_cmd_wdata,
  input  icb_bus_pkg::mask_t i_icb_cmd_wmask,
  input  icb_bus_pkg::size_t i_icb_cmd_size,

  output logic               o_icb_rsp_valid,
  input  logic               i_icb_rsp_ready,
  output icb_bus_pkg::data_t o_icb_rsp_rdata,
  output logic               o_icb_rsp_err,

  output logic               o_port_cmd_valid [`ICB_PORT_NUM],
  input  logic               i_port_cmd_ready [`ICB_PORT_NUM],
  output icb_bus_pkg::addr_t o_port_cmd_addr  [`ICB_PORT_NUM],
  output logic               o_port_cmd_read  [`ICB_PORT_NUM],
  output icb_bus_pkg::data_t o_port_cmd_wdata [`ICB_PORT_NUM],
  output icb_bus_pkg::mask_t o_port_cmd_wmask [`ICB_PORT_NUM],
  output icb_bus_pkg::size_t o_port_cmd_size  [`ICB_PORT_NUM],

  input  logic               i_port_rsp_valid [`ICB_PORT_NUM],
  output logic               o_port_rsp_ready [`ICB_PORT_NUM],
  input  icb_bus_pkg::data_t i_port_rsp_rdata [`ICB_PORT_NUM],
  input  logic               i_port_rsp_err   [`ICB_PORT_NUM]
);

  import icb_bus_pkg::*;

  splt_port_e sel_port;
  splt_port_e head_port;
  splt_port_e last_port;
  splt_port_e push_port;
  logic       fifo_empty;
  logic       fifo_full;
  logic       push;
  logic       pop;

  icb_region_decode u_region_decode (
    .i_cmd_addr    (i_icb_cmd_addr),
    .i_port_enable (i_port_enable),
    .o_sel_port    (sel_port)
  );

  icb_outs_fifo u_outs_fifo (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_push      (push),
    .i_push_port (push_port),
    .i_pop       (pop),
    .o_head_port (head_port),
    .o_last_port (last_port),
    .o_empty     (fifo_empty),
    .o_full      (fifo_full)
  );

  icb_splt_route u_splt_route (
    .i_icb_cmd_valid  (i_icb_cmd_valid),
    .i_icb_cmd_addr   (i_icb_cmd_addr),
    .i_icb_cmd_read   (i_icb_cmd_read),
    .i_icb_cmd_wdata  (i_icb_cmd_wdata),
    .i_icb_cmd_wmask  (i_icb_cmd_wmask),
    .i_icb_cmd_size   (i_icb_cmd_size),
    .o_icb_cmd_ready  (o_icb_cmd_ready),

    .i_sel_port       (sel_port),
    .i_head_port      (head_port),
    .i_last_port      (last_port),
    .i_fifo_empty     (fifo_empty),
    .i_fifo_full      (fifo_full),
    .o_push           (push),
    .o_push_port      (push_port),
    .o_pop            (pop),

    .o_port_cmd_valid (o_port_cmd_valid),
    .o_port_cmd_addr  (o_port_cmd_addr),
    .o_port_cmd_read  (o_port_cmd_read),
    .o_port_cmd_wdata (o_port_cmd_wdata),
    .o_port_cmd_wmask (o_port_cmd_wmask),
    .o_port_cmd_size  (o_port_cmd_size),
    .i_port_cmd_ready (i_port_cmd_ready),

    .i_port_rsp_valid (i_port_rsp_valid),
    .i_port_rsp_rdata (i_port_rsp_rdata),
    .i_port_rsp_err   (i_port_rsp_err),
    .o_port_rsp_ready (o_port_rsp_ready),

    .o_icb_rsp_valid  (o_icb_rsp_valid),
    .o_icb_rsp_rdata  (o_icb_rsp_rdata),
    .o_icb_rsp_err    (o_icb_rsp_err),
    .i_icb_rsp_ready  (i_icb_rsp_ready)
  );

endmodule

//--- icb_bus_consts.svh
`ifndef ICB_BUS_CONSTS_SVH
`define ICB_BUS_CONSTS_SVH

// Bus widths
`define ICB_AW 32
`define ICB_DW 32

// Target ports and outstanding limit
`define ICB_PORT_NUM 4
`define ICB_OUTS_NUM 2

// Region match uses address bits [ICB_AW-1:ICB_REGION_LSB], 4 KiB per region
`define ICB_REGION_LSB 12

`define ICB_O0_BASE 32'h0000_1000
`define ICB_O1_BASE 32'h0000_2000
`define ICB_O2_BASE 32'h0000_3000

`endif

//--- icb_bus_pkg.sv
`include "icb_bus_consts.svh"

package icb_bus_pkg;

  typedef logic [`ICB_AW-1:0]   addr_t;  // Command address
  typedef logic [`ICB_DW-1:0]   data_t;  // Write and read data
  typedef logic [`ICB_DW/8-1:0] mask_t;  // One bit per byte lane
  typedef logic [1:0]           size_t;  // Transfer size code

  // Target port number, also used as array index
  typedef enum logic [1:0] {
    PORT_0 = 2'd0,
    PORT_1 = 2'd1,
    PORT_2 = 2'd2,
    PORT_3 = 2'd3  // Default port
  } splt_port_e;

endpackage

//--- icb_outs_fifo.sv
`timescale 1ns/1ps
`include "icb_bus_consts.svh"

module icb_outs_fifo (
  input  logic                    clk,
  input  logic                    i_arst_n,
  input  logic                    i_push,
  input  icb_bus_pkg::splt_port_e i_push_port,
  input  logic                    i_pop,
  output icb_bus_pkg::splt_port_e o_head_port,
  output icb_bus_pkg::splt_port_e o_last_port,
  output logic                    o_empty,
  output logic                    o_full
);

  import icb_bus_pkg::*;

  localparam int DEPTH = `ICB_OUTS_NUM;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  splt_port_e       mem [DEPTH];  // Ports still owing a response
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  splt_port_e       last_q;       // Port of the youngest command

  // Pointer wrap also covers a depth that is not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      last_q <= PORT_0;
    end else begin
      if (i_push) begin
        wr_ptr <= next_ptr(wr_ptr);
        last_q <= i_push_port;
      end
      if (i_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_port;
    end
  end

  assign o_head_port = mem[rd_ptr];
  assign o_last_port = last_q;
  assign o_empty     = (count == '0);
  assign o_full      = (count == CNT_W'(DEPTH));

  // The route must hold off commands and responses at the queue limits
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!i_arst_n) i_push |-> !o_full
  ) else $error("Push into full outstanding queue");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!i_arst_n) i_pop |-> !o_empty
  ) else $error("Pop from empty outstanding queue");

endmodule

//--- icb_region_decode.sv
`timescale 1ns/1ps
`include "icb_bus_consts.svh"

module icb_region_decode (
  input  icb_bus_pkg::addr_t      i_cmd_addr,
  input  logic [2:0]              i_port_enable,
  output icb_bus_pkg::splt_port_e o_sel_port
);

  import icb_bus_pkg::*;

  localparam int MSB = `ICB_AW - 1;
  localparam int LSB = `ICB_REGION_LSB;

  localparam addr_t REGION_BASE [3] = '{`ICB_O0_BASE, `ICB_O1_BASE, `ICB_O2_BASE};

  logic [2:0] hit;

  for (genvar g = 0; g < 3; g++) begin : g_region
    localparam addr_t BASE = REGION_BASE[g];
    assign hit[g] = i_port_enable[g] && (i_cmd_addr[MSB:LSB] == BASE[MSB:LSB]);
  end

  // Lowest enabled region wins, the rest fall through to port 3
  always_comb begin
    if (hit[0]) begin
      o_sel_port = PORT_0;
    end else if (hit[1]) begin
      o_sel_port = PORT_1;
    end else if (hit[2]) begin
      o_sel_port = PORT_2;
    end else begin
      o_sel_port = PORT_3;
    end
  end

endmodule

//--- icb_splt_route.sv
`timescale 1ns/1ps
`include "icb_bus_consts.svh"

module icb_splt_route (
  input  logic                    i_icb_cmd_valid,
  input  icb_bus_pkg::addr_t      i_icb_cmd_addr,
  input  logic                    i_icb_cmd_read,
  input  icb_bus_pkg::data_t      i_icb_cmd_wdata,
  input  icb_bus_pkg::mask_t      i_icb_cmd_wmask,
  input  icb_bus_pkg::size_t      i_icb_cmd_size,
  output logic                    o_icb_cmd_ready,

  input  icb_bus_pkg::splt_port_e i_sel_port,
  input  icb_bus_pkg::splt_port_e i_head_port,
  input  icb_bus_pkg::splt_port_e i_last_port,
  input  logic                    i_fifo_empty,
  input  logic                    i_fifo_full,
  output logic                    o_push,
  output icb_bus_pkg::splt_port_e o_push_port,
  output logic                    o_pop,

  output logic                    o_port_cmd_valid [`ICB_PORT_NUM],
  output icb_bus_pkg::addr_t      o_port_cmd_addr  [`ICB_PORT_NUM],
  output logic                    o_port_cmd_read  [`ICB_PORT_NUM],
  output icb_bus_pkg::data_t      o_port_cmd_wdata [`ICB_PORT_NUM],
  output icb_bus_pkg::mask_t      o_port_cmd_wmask [`ICB_PORT_NUM],
  output icb_bus_pkg::size_t      o_port_cmd_size  [`ICB_PORT_NUM],
  input  logic                    i_port_cmd_ready [`ICB_PORT_NUM],

  input  logic                    i_port_rsp_valid [`ICB_PORT_NUM],
  input  icb_bus_pkg::data_t      i_port_rsp_rdata [`ICB_PORT_NUM],
  input  logic                    i_port_rsp_err   [`ICB_PORT_NUM],
  output logic                    o_port_rsp_ready [`ICB_PORT_NUM],

  output logic                    o_icb_rsp_valid,
  output icb_bus_pkg::data_t      o_icb_rsp_rdata,
  output logic                    o_icb_rsp_err,
  input  logic                    i_icb_rsp_ready
);

  import icb_bus_pkg::*;

  logic cmd_allow;
  logic sel_ready;
  logic cmd_hsk;
  logic rsp_valid;

  // A different port has to wait for the queue to drain
  assign cmd_allow = !i_fifo_full && (i_fifo_empty || (i_sel_port == i_last_port));

  assign sel_ready       = i_port_cmd_ready[i_sel_port];
  assign o_icb_cmd_ready = cmd_allow && sel_ready;
  assign cmd_hsk         = i_icb_cmd_valid && o_icb_cmd_ready;

  assign o_push      = cmd_hsk;
  assign o_push_port = i_sel_port;

  for (genvar g = 0; g < `ICB_PORT_NUM; g++) begin : g_port
    logic port_vld;
    logic port_head;

    assign port_vld  = i_icb_cmd_valid && cmd_allow && (i_sel_port == splt_port_e'(g));
    assign port_head = !i_fifo_empty && (i_head_port == splt_port_e'(g));

    assign o_port_cmd_valid[g] = port_vld;
    assign o_port_cmd_addr[g]  = port_vld ? i_icb_cmd_addr  : '0;  // Masked off when idle
    assign o_port_cmd_read[g]  = port_vld ? i_icb_cmd_read  : 1'b0;
    assign o_port_cmd_wdata[g] = port_vld ? i_icb_cmd_wdata : '0;
    assign o_port_cmd_wmask[g] = port_vld ? i_icb_cmd_wmask : '0;
    assign o_port_cmd_size[g]  = port_vld ? i_icb_cmd_size  : '0;

    assign o_port_rsp_ready[g] = port_head && i_icb_rsp_ready;  // Only the head may answer
  end

  // Responses come back in command order from the queue head
  assign rsp_valid       = !i_fifo_empty && i_port_rsp_valid[i_head_port];
  assign o_icb_rsp_valid = rsp_valid;
  assign o_icb_rsp_rdata = rsp_valid ? i_port_rsp_rdata[i_head_port] : '0;
  assign o_icb_rsp_err   = rsp_valid && i_port_rsp_err[i_head_port];

  assign o_pop = rsp_valid && i_icb_rsp_ready;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1
set -o pipefail

verilator --binary --timing --top-module tb_icb1to4_bus -f icb1to4_bus.f \
  -o sim_icb1to4_bus > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_icb1to4_bus > sim.log 2>&1 \
  || echo "Simulator returned a failing status"

grep -qx "No errors" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk    = 1'b0;
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;  // Released away from the active edge
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- tb_icb1to4_bus.sv
`timescale 1ns/1ps
`include "icb_bus_consts.svh"

module tb_icb1to4_bus;

  import icb_bus_pkg::*;

  localparam int NP       = `ICB_PORT_NUM;
  localparam int OUTS     = `ICB_OUTS_NUM;
  localparam int NUM_ROWS = 16;
  localparam int GEN_SLOT = NUM_ROWS;  // Reset and end of run checks
  localparam int CLK_NS   = 10;
  localparam int MAX_PEND = 4;

  typedef struct packed {
    addr_t      addr;
    logic       read;
    data_t      wdata;
    mask_t      mask;
    size_t      size;
    logic [2:0] en;
    logic [2:0] delay;     // Response latency, 1 to 4 cycles
    logic       err;
    logic [2:0] hold;      // Cycles with initiator rsp ready held low
    splt_port_e exp_port;
  } row_t;

  logic       clk;
  logic       i_arst_n;
  logic [2:0] i_port_enable;
  logic       i_icb_cmd_valid;
  logic       o_icb_cmd_ready;
  addr_t      i_icb_cmd_addr;
  logic       i_icb_cmd_read;
  data_t      i_icb_cmd_wdata;
  mask_t      i_icb_cmd_wmask;
  size_t      i_icb_cmd_size;
  logic       o_icb_rsp_valid;
  logic       i_icb_rsp_ready;
  data_t      o_icb_rsp_rdata;
  logic       o_icb_rsp_err;
  logic       o_port_cmd_valid [NP];
  logic       i_port_cmd_ready [NP];
  addr_t      o_port_cmd_addr  [NP];
  logic       o_port_cmd_read  [NP];
  data_t      o_port_cmd_wdata [NP];
  mask_t      o_port_cmd_wmask [NP];
  size_t      o_port_cmd_size  [NP];
  logic       i_port_rsp_valid [NP];
  logic       o_port_rsp_ready [NP];
  data_t      i_port_rsp_rdata [NP];
  logic       i_port_rsp_err   [NP];

  row_t   tbl [NUM_ROWS];
  int     cur_row;
  int     rsp_row;
  int     row_errs [NUM_ROWS + 1];
  int     err_cnt;
  integer seed;

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) u_clk_gen (
    .o_clk    (clk),
    .o_arst_n (i_arst_n)
  );

  icb1to4_bus u_icb1to4_bus (
    .clk (clk), .i_arst_n (i_arst_n), .i_port_enable (i_port_enable),
    .i_icb_cmd_valid (i_icb_cmd_valid), .o_icb_cmd_ready (o_icb_cmd_ready),
    .i_icb_cmd_addr (i_icb_cmd_addr), .i_icb_cmd_read (i_icb_cmd_read),
    .i_icb_cmd_wdata (i_icb_cmd_wdata), .i_icb_cmd_wmask (i_icb_cmd_wmask),
    .i_icb_cmd_size (i_icb_cmd_size),
    .o_icb_rsp_valid (o_icb_rsp_valid), .i_icb_rsp_ready (i_icb_rsp_ready),
    .o_icb_rsp_rdata (o_icb_rsp_rdata), .o_icb_rsp_err (o_icb_rsp_err),
    .o_port_cmd_valid (o_port_cmd_valid), .i_port_cmd_ready (i_port_cmd_ready),
    .o_port_cmd_addr (o_port_cmd_addr), .o_port_cmd_read (o_port_cmd_read),
    .o_port_cmd_wdata (o_port_cmd_wdata), .o_port_cmd_wmask (o_port_cmd_wmask),
    .o_port_cmd_size (o_port_cmd_size),
    .i_port_rsp_valid (i_port_rsp_valid), .o_port_rsp_ready (o_port_rsp_ready),
    .i_port_rsp_rdata (i_port_rsp_rdata), .i_port_rsp_err (i_port_rsp_err)
  );

  task automatic note_error(input int row);
    err_cnt++;
    row_errs[row]++;
  endtask

  task automatic check_bit(input int row, input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %b expected %b", $time, row, what, got, exp);
      note_error(row);
    end
  endtask

  task automatic check_data(input int row, input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %h expected %h", $time, row, what, got, exp);
      note_error(row);
    end
  endtask

  task automatic check_port(input int row, input string what, input splt_port_e got,
                            input splt_port_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: row %0d %s got %s expected %s",
               $time, row, what, got.name(), exp.name());
      note_error(row);
    end
  endtask

  function automatic row_t make_row(input addr_t a, input logic rd, input data_t wd,
                                    input mask_t m, input size_t sz, input logic [2:0] en,
                                    input int dly, input logic er, input int hold,
                                    input splt_port_e p);
    row_t r;
    r = '{addr: a, read: rd, wdata: wd, mask: m, size: sz, en: en, delay: 3'(dly),
          err: er, hold: 3'(hold), exp_port: p};
    return r;
  endfunction

  task automatic build_table();
    tbl[0]  = make_row(32'h1004, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 1, 1'b0, 0, PORT_0);
    tbl[1]  = make_row(32'h2008, 1'b0, 32'h1234_5678, 4'h3, 2'd1, 3'b111, 2, 1'b0, 1, PORT_1);
    tbl[2]  = make_row(32'h3ffc, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 3, 1'b1, 0, PORT_2);
    tbl[3]  = make_row(32'h0010, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 1, 1'b0, 2, PORT_3);
    tbl[4]  = make_row(32'h4000, 1'b0, 32'hdead_beef, 4'h1, 2'd0, 3'b111, 2, 1'b1, 0, PORT_3);
    tbl[5]  = make_row(32'h1100, 1'b1, 32'h0, 4'hf, 2'd2, 3'b110, 1, 1'b0, 0, PORT_3);
    tbl[6]  = make_row(32'h2200, 1'b0, 32'h0bad_f00d, 4'hc, 2'd1, 3'b101, 3, 1'b0, 1, PORT_3);
    tbl[7]  = make_row(32'h3300, 1'b1, 32'h0, 4'hf, 2'd2, 3'b011, 2, 1'b0, 0, PORT_3);
    tbl[8]  = make_row(32'h1010, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 4, 1'b0, 0, PORT_0);
    tbl[9]  = make_row(32'h1014, 1'b0, 32'hcafe_0001, 4'h8, 2'd0, 3'b111, 4, 1'b1, 0, PORT_0);
    tbl[10] = make_row(32'h1018, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 4, 1'b0, 2, PORT_0);
    tbl[11] = make_row(32'h2ff0, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 1, 1'b0, 3, PORT_1);
    tbl[12] = make_row(32'h2ff4, 1'b0, 32'h5555_aaaa, 4'hf, 2'd2, 3'b111, 2, 1'b0, 0, PORT_1);
    tbl[13] = make_row(32'h1_1000, 1'b1, 32'h0, 4'hf, 2'd2, 3'b111, 3, 1'b1, 0, PORT_3);
    tbl[14] = make_row(32'h3000, 1'b0, 32'h0f0f_0f0f, 4'h6, 2'd1, 3'b111, 4, 1'b0, 2, PORT_2);
    tbl[15] = make_row(32'h0fff, 1'b1, 32'h0, 4'h1, 2'd0, 3'b111, 1, 1'b0, 0, PORT_3);
  endtask

  // Target port models
  int    cyc;
  int    pend_n    [NP];
  int    pend_due  [NP][MAX_PEND];
  data_t pend_data [NP][MAX_PEND];
  logic  pend_err  [NP][MAX_PEND];

  initial begin : port_drive
    seed = 8109;
    for (int p = 0; p < NP; p++) begin
      i_port_cmd_ready[p] = 1'b0;
      i_port_rsp_valid[p] = 1'b0;
      i_port_rsp_rdata[p] = '0;
      i_port_rsp_err[p]   = 1'b0;
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < NP; p++) begin
        i_port_cmd_ready[p] = ($random(seed) & 3) != 0;  // Ready about three cycles in four
        if (pend_n[p] > 0 && cyc >= pend_due[p][0]) begin
          i_port_rsp_valid[p] = 1'b1;
          i_port_rsp_rdata[p] = pend_data[p][0];
          i_port_rsp_err[p]   = pend_err[p][0];
        end else begin
          i_port_rsp_valid[p] = 1'b0;
          i_port_rsp_rdata[p] = '0;
          i_port_rsp_err[p]   = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin : port_sample
    if (i_arst_n) begin
      for (int p = 0; p < NP; p++) begin
        if (o_port_rsp_ready[p] && i_port_rsp_valid[p]) begin
          for (int k = 1; k < MAX_PEND; k++) begin
            pend_due[p][k-1]  = pend_due[p][k];
            pend_data[p][k-1] = pend_data[p][k];
            pend_err[p][k-1]  = pend_err[p][k];
          end
          pend_n[p]--;
        end
        if (o_port_cmd_valid[p] && i_port_cmd_ready[p] && pend_n[p] < MAX_PEND) begin
          pend_due[p][pend_n[p]]  = cyc + int'(tbl[cur_row].delay);
          pend_data[p][pend_n[p]] = (o_port_cmd_addr[p] ^ 32'hA5A5_0000) + data_t'(p);
          pend_err[p][pend_n[p]]  = tbl[cur_row].err;
          pend_n[p]++;
        end
      end
      cyc++;
    end
  end

  // Acceptance and response steering, from the count of commands still owed a response
  int         mon_pend;
  splt_port_e mon_port;

  always @(posedge clk) begin : bus_rules
    logic       allow;
    splt_port_e exp_p;
    if (!i_arst_n) begin
      mon_pend = 0;
      mon_port = PORT_0;
    end else begin
      exp_p = tbl[cur_row].exp_port;
      allow = (mon_pend < OUTS) && (mon_pend == 0 || mon_port == exp_p);
      if (i_icb_cmd_valid) begin
        check_bit(cur_row, "selected port cmd valid", o_port_cmd_valid[exp_p], allow);
        check_bit(cur_row, "cmd ready", o_icb_cmd_ready, allow && i_port_cmd_ready[exp_p]);
      end
      for (int p = 0; p < NP; p++) begin
        check_bit(rsp_row, $sformatf("port %0d rsp ready", p), o_port_rsp_ready[p],
                  (mon_pend > 0) && (mon_port == splt_port_e'(p)) && i_icb_rsp_ready);
      end
      if (mon_pend == 0) begin
        check_bit(rsp_row, "rsp valid with nothing pending", o_icb_rsp_valid, 1'b0);
      end
      if (o_icb_rsp_valid && i_icb_rsp_ready) begin
        mon_pend--;
      end
      if (i_icb_cmd_valid && o_icb_cmd_ready) begin
        mon_pend++;
        mon_port = exp_p;
      end
    end
  end

  function automatic splt_port_e valid_port();
    splt_port_e found;
    found = PORT_3;
    for (int p = NP - 1; p >= 0; p--) begin
      if (o_port_cmd_valid[p]) begin
        found = splt_port_e'(p);
      end
    end
    return found;
  endfunction

  task automatic check_payload(input int row, input row_t r);
    for (int p = 0; p < NP; p++) begin
      if (splt_port_e'(p) == r.exp_port) begin
        if (o_port_cmd_valid[p]) begin
          check_data(row, "fwd addr", o_port_cmd_addr[p], r.addr);
          check_bit(row, "fwd read", o_port_cmd_read[p], r.read);
          check_data(row, "fwd wdata", o_port_cmd_wdata[p], r.wdata);
          check_data(row, "fwd mask", data_t'(o_port_cmd_wmask[p]), data_t'(r.mask));
          check_data(row, "fwd size", data_t'(o_port_cmd_size[p]), data_t'(r.size));
        end
      end else begin
        check_bit(row, $sformatf("port %0d valid", p), o_port_cmd_valid[p], 1'b0);
        check_data(row, $sformatf("port %0d addr", p), o_port_cmd_addr[p], '0);
        check_bit(row, $sformatf("port %0d read", p), o_port_cmd_read[p], 1'b0);
        check_data(row, $sformatf("port %0d wdata", p), o_port_cmd_wdata[p], '0);
        check_data(row, $sformatf("port %0d mask", p), data_t'(o_port_cmd_wmask[p]), '0);
        check_data(row, $sformatf("port %0d size", p), data_t'(o_port_cmd_size[p]), '0);
      end
    end
  endtask

  task automatic drive_commands();
    row_t r;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = tbl[i];
      @(negedge clk);
      cur_row         = i;
      i_port_enable   = r.en;
      i_icb_cmd_valid = 1'b1;
      i_icb_cmd_addr  = r.addr;
      i_icb_cmd_read  = r.read;
      i_icb_cmd_wdata = r.wdata;
      i_icb_cmd_wmask = r.mask;
      i_icb_cmd_size  = r.size;
      do begin
        @(posedge clk);
        check_payload(i, r);
      end while (!o_icb_cmd_ready);
      check_port(i, "target port", valid_port(), r.exp_port);
    end
    @(negedge clk);
    i_icb_cmd_valid = 1'b0;
  endtask

  task automatic report_row(input int row);
    if (row_errs[row] == 0) begin
      $display("Row %0d to port %0d: ok", row, tbl[row].exp_port);
    end else begin
      $display("Row %0d to port %0d: %0d failed checks", row, tbl[row].exp_port, row_errs[row]);
    end
  endtask

  task automatic collect_responses();
    row_t  r;
    data_t exp_rdata;
    data_t held_rdata;
    logic  held_err;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = tbl[i];
      exp_rdata = (r.addr ^ 32'hA5A5_0000) + data_t'(r.exp_port);
      @(posedge clk);
      while (!o_icb_rsp_valid) begin
        @(posedge clk);
      end
      held_rdata = o_icb_rsp_rdata;
      held_err   = o_icb_rsp_err;
      for (int h = 0; h < int'(r.hold); h++) begin
        @(posedge clk);
        check_bit(i, "rsp valid while held", o_icb_rsp_valid, 1'b1);
        check_data(i, "rsp rdata while held", o_icb_rsp_rdata, held_rdata);
        check_bit(i, "rsp err while held", o_icb_rsp_err, held_err);
      end
      @(negedge clk);
      i_icb_rsp_ready = 1'b1;
      @(posedge clk);
      check_bit(i, "rsp valid", o_icb_rsp_valid, 1'b1);
      check_data(i, "rsp rdata", o_icb_rsp_rdata, exp_rdata);
      check_bit(i, "rsp err", o_icb_rsp_err, r.err);
      @(negedge clk);
      i_icb_rsp_ready = 1'b0;
      rsp_row = i + 1;
      report_row(i);
    end
  endtask

  initial begin : main
    int n_fail;
    i_port_enable   = 3'b111;
    i_icb_cmd_valid = 1'b0;
    i_icb_cmd_addr  = '0;
    i_icb_cmd_read  = 1'b0;
    i_icb_cmd_wdata = '0;
    i_icb_cmd_wmask = '0;
    i_icb_cmd_size  = '0;
    i_icb_rsp_ready = 1'b0;
    cur_row = 0;
    rsp_row = 0;
    err_cnt = 0;
    build_table();
    wait (i_arst_n === 1'b1);
    @(negedge clk);
    check_bit(GEN_SLOT, "rsp valid after reset", o_icb_rsp_valid, 1'b0);
    for (int p = 0; p < NP; p++) begin
      check_bit(GEN_SLOT, $sformatf("port %0d cmd valid after reset", p), o_port_cmd_valid[p], 1'b0);
      check_bit(GEN_SLOT, $sformatf("port %0d rsp ready after reset", p), o_port_rsp_ready[p], 1'b0);
    end
    $display("Reset state: %0d failed checks", row_errs[GEN_SLOT]);
    fork
      drive_commands();
      collect_responses();
    join
    repeat (4) @(negedge clk);
    check_bit(GEN_SLOT, "rsp valid after last row", o_icb_rsp_valid, 1'b0);
    for (int p = 0; p < NP; p++) begin
      check_bit(GEN_SLOT, $sformatf("port %0d model drained", p), pend_n[p] == 0, 1'b1);
    end
    n_fail = 0;
    for (int i = 0; i <= NUM_ROWS; i++) begin
      if (row_errs[i] != 0) begin
        n_fail++;
      end
    end
    $display("Tests run: %0d, failed: %0d, failed checks: %0d", NUM_ROWS + 1, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(NUM_ROWS * 50 * CLK_NS);
    $display("Timeout: run still busy after %0d cycles", NUM_ROWS * 50);
    $display("Errors found");
    $finish;
  end

endmodule
